// File: eth_udp_link.f
hdl/eth_pkg.sv
hdl/frame_if.sv
hdl/byte_fifo.sv
hdl/udp_frame_tx.sv
hdl/gmii_rx_parser.sv
hdl/rx_result.sv
hdl/eth_udp_link.sv
dv/tb_eth_udp_link.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_eth_udp_link
FILELIST  ?= eth_udp_link.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps

SIM_BIN = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "Result: FAIL"; exit 1; fi
	@if ! grep -q "sim passed" $(LOG); then echo "Result: FAIL, no pass line"; exit 1; fi
	@echo "Result: PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/tb_eth_udp_link.sv
`timescale 1ns/10ps

module tb_eth_udp_link import eth_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 4000;   // 12 frames with writes and gaps, plus margin
    localparam int HDR_BYTES      = 10;     // Preamble, SFD, two length bytes

    logic  clk = 1'b0;
    logic  rst;
    logic  fifo_wr_en;
    byte_t fifo_wr_data;
    logic  fs_send;
    len_t  tx_dlen;
    logic  e_rxdv;
    byte_t e_rxd;
    logic  fifo_full;
    logic  fd_send;
    logic  e_txen;
    byte_t e_txd;
    logic  fs_recv;
    len_t  rx_dlen;
    logic  rx_err;
    logic  rx_data_en;
    byte_t rx_data;

    logic  corrupt;
    int    corrupt_idx;
    int    txpos = 0;        // Byte position within the frame on e_txd
    logic  txen_d = 1'b0;
    int    cycles = 0;
    int    errors = 0;
    int    sent = 0;
    int    tx_frames = 0;
    int    rx_frames = 0;

    byte_t tx_exp_q[$];
    int    tx_len_q[$];
    byte_t rx_exp_q[$];
    int    rx_len_q[$];
    logic  rx_err_q[$];
    byte_t tx_got[$];
    byte_t rx_got[$];

    eth_udp_link dut0 (.*);

    always #4 clk = ~clk;

    // Loopback, one payload bit flipped in corrupt mode
    assign e_rxdv = e_txen;
    assign e_rxd  = (corrupt && txpos == HDR_BYTES + corrupt_idx) ? (e_txd ^ 8'h01) : e_txd;

    function automatic byte_t ref_chk(input byte_t d[$]);
        byte_t s;
        s = 8'h00;
        foreach (d[i]) s = s + d[i];   // Sum mod 256
        return s;
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %0h expected %0h", $time, msg, got, exp);
        end
    endtask

    task automatic check_tx_frame();
        int    n;
        int    i;
        byte_t pl[$];
        byte_t exp_f[$];
        n = tx_len_q.pop_front();
        for (i = 0; i < n; i++) pl.push_back(tx_exp_q.pop_front());
        for (i = 0; i < 7; i++) exp_f.push_back(8'h55);
        exp_f.push_back(8'hD5);
        exp_f.push_back(n[15:8]);
        exp_f.push_back(n[7:0]);
        for (i = 0; i < n; i++) exp_f.push_back(pl[i]);
        exp_f.push_back(ref_chk(pl));
        check(tx_got.size(), 11 + n, "e_txen high cycles");
        for (i = 0; i < exp_f.size() && i < tx_got.size(); i++)
            check(32'(tx_got[i]), 32'(exp_f[i]), $sformatf("e_txd byte %0d", i));
        check(32'(fd_send), 1, "fd_send after e_txen falls");
        tx_got.delete();
        tx_frames++;
    endtask

    task automatic check_rx_frame();
        int    n;
        int    i;
        byte_t b;
        if (rx_len_q.size() == 0) begin
            errors++;
            $display("Error at %0t: fs_recv seen with no frame outstanding", $time);
        end else begin
            n = rx_len_q.pop_front();
            check(32'(rx_dlen), n, "rx_dlen");
            check(32'(rx_err), 32'(rx_err_q.pop_front()), "rx_err");
            check(rx_got.size(), n, "rx byte count");
            for (i = 0; i < n; i++) begin
                b = rx_exp_q.pop_front();
                if (i < rx_got.size())
                    check(32'(rx_got[i]), 32'(b), $sformatf("rx_data byte %0d", i));
            end
        end
        rx_got.delete();
        rx_frames++;
    endtask

    // TX side monitor
    always @(posedge clk) begin
        if (!rst) begin
            if (e_txen) tx_got.push_back(e_txd);
            if (txen_d && !e_txen && tx_len_q.size() != 0) check_tx_frame();
            else check(32'(fd_send), 0, "fd_send outside frame end");
        end
        txen_d <= e_txen;
        txpos  <= e_txen ? txpos + 1 : 0;
    end

    // Comparison of the received stream
    always @(posedge clk) begin
        if (!rst) begin
            if (rx_data_en) rx_got.push_back(rx_data);
            if (fs_recv) check_rx_frame();
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("Timeout: run not finished after %0d cycles", TIMEOUT_CYCLES);
            $display("sim failed");
            $finish;
        end
    end

    // Only the first n bytes of pl go out in the frame
    task automatic expect_frame(input byte_t pl[$], input int n, input int bad_idx);
        int i;
        tx_len_q.push_back(n);
        rx_len_q.push_back(n);
        rx_err_q.push_back(bad_idx >= 0);
        for (i = 0; i < n; i++) begin
            tx_exp_q.push_back(pl[i]);
            rx_exp_q.push_back((i == bad_idx) ? (pl[i] ^ 8'h01) : pl[i]);
        end
        sent++;
    endtask

    task automatic write_bytes(input byte_t d[$]);
        foreach (d[i]) begin
            @(posedge clk);
            check(32'(fifo_full), 0, "fifo_full while filling");
            check(32'(e_txen), 0, "e_txen before payload complete");
            fifo_wr_en   <= 1'b1;
            fifo_wr_data <= d[i];
        end
        @(posedge clk);
        fifo_wr_en <= 1'b0;
    endtask

    task automatic pulse_send(input int n);
        @(posedge clk);
        fs_send <= 1'b1;
        tx_dlen <= 16'(n);
        @(posedge clk);
        fs_send <= 1'b0;
        tx_dlen <= 16'h0000;
    endtask

    task automatic finish_frame();
        @(posedge clk);
        while (!fd_send) @(posedge clk);
        corrupt <= 1'b0;
        repeat (64) @(posedge clk);   // Inter-frame gap
        check(rx_frames, sent, "frames received");
    endtask

    task automatic send_frame(input int n, input bit early, input int bad_idx);
        byte_t pl[$];
        int    i;
        for (i = 0; i < n; i++) pl.push_back(8'($urandom));
        expect_frame(pl, n, bad_idx);
        corrupt     <= (bad_idx >= 0);
        corrupt_idx <= bad_idx;
        if (early) pulse_send(n);
        write_bytes(pl);
        if (!early) pulse_send(n);
        finish_frame();
    endtask

    initial begin
        byte_t pl[$];
        int    i;
        int    n;
        void'($urandom(32'hbbce_aa01));
        rst          <= 1'b1;
        fifo_wr_en   <= 1'b0;
        fifo_wr_data <= 8'h00;
        fs_send      <= 1'b0;
        tx_dlen      <= 16'h0000;
        corrupt      <= 1'b0;
        corrupt_idx  <= 0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check(32'(e_txen), 0, "e_txen after reset");
        check(32'(fd_send), 0, "fd_send after reset");
        check(32'(fs_recv), 0, "fs_recv after reset");
        check(32'(rx_data_en), 0, "rx_data_en after reset");
        check(32'(rx_err), 0, "rx_err after reset");
        check(32'(fifo_full), 0, "fifo_full after reset");

        for (i = 0; i < 5; i++) send_frame(int'($urandom_range(64, 1)), 1'b0, -1);
        for (i = 0; i < 2; i++) begin
            n = int'($urandom_range(64, 1));
            send_frame(n, 1'b0, int'($urandom_range(n - 1, 0)));
        end
        send_frame(48, 1'b1, -1);    // fs_send ahead of the payload
        for (i = 0; i < 3; i++) send_frame(int'($urandom_range(64, 1)), 1'b0, -1);

        for (i = 0; i < 65; i++) pl.push_back(8'($urandom));
        expect_frame(pl, 64, -1);    // 65th byte is dropped
        write_bytes(pl);
        check(32'(fifo_full), 1, "fifo_full after 64 writes");
        pulse_send(64);
        finish_frame();
        check(32'(fifo_full), 0, "FIFO drained after full frame");

        check(tx_frames, 12, "frames transmitted");
        check(rx_frames, 12, "frames delivered");
        $display("Done: %0d errors, %0d frames sent, %0d received",
                 errors, tx_frames, rx_frames);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: hdl/eth_udp_link.sv
`timescale 1ns/10ps

module eth_udp_link import eth_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  fifo_wr_en,
    input  byte_t fifo_wr_data,
    input  logic  fs_send,
    input  len_t  tx_dlen,
    input  logic  e_rxdv,
    input  byte_t e_rxd,
    output logic  fifo_full,
    output logic  fd_send,
    output logic  e_txen,
    output byte_t e_txd,
    output logic  fs_recv,
    output len_t  rx_dlen,
    output logic  rx_err,
    output logic  rx_data_en,
    output byte_t rx_data
);

    logic             fifo_rd_en;
    byte_t            fifo_dout;
    logic [FIFO_AW:0] fifo_level;

    frame_if fr_if ();

    byte_fifo u_fifo (
        .clk   (clk),
        .rst   (rst),
        .wr_en (fifo_wr_en),
        .din   (fifo_wr_data),
        .rd_en (fifo_rd_en),
        .dout  (fifo_dout),
        .full  (fifo_full),
        .level (fifo_level)
    );

    udp_frame_tx u_tx (
        .clk        (clk),
        .rst        (rst),
        .fs_send    (fs_send),
        .tx_dlen    (tx_dlen),
        .fifo_dout  (fifo_dout),
        .fifo_level (fifo_level),
        .fifo_rd_en (fifo_rd_en),
        .e_txen     (e_txen),
        .e_txd      (e_txd),
        .fd_send    (fd_send)
    );

    gmii_rx_parser u_rx (
        .clk    (clk),
        .rst    (rst),
        .e_rxdv (e_rxdv),
        .e_rxd  (e_rxd),
        .fr     (fr_if)
    );

    rx_result u_res (
        .clk        (clk),
        .rst        (rst),
        .fr         (fr_if),
        .rx_data_en (rx_data_en),
        .rx_data    (rx_data),
        .fs_recv    (fs_recv),
        .rx_dlen    (rx_dlen),
        .rx_err     (rx_err)
    );

endmodule

// File: hdl/rx_result.sv
`timescale 1ns/10ps

module rx_result import eth_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    frame_if.dst  fr,
    output logic  rx_data_en,
    output byte_t rx_data,
    output logic  fs_recv,
    output len_t  rx_dlen,
    output logic  rx_err
);

    len_t cnt;        // Delivered payload bytes
    logic in_frame;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_data_en <= 1'b0;
            fs_recv    <= 1'b0;
            rx_err     <= 1'b0;
            cnt        <= '0;
            in_frame   <= 1'b0;
        end else begin
            rx_data_en <= fr.data_en;
            fs_recv    <= fr.eof;
            if (fr.sof) begin
                cnt      <= '0;
                in_frame <= 1'b1;
            end else if (fr.data_en) begin
                cnt <= cnt + 1'b1;
            end
            if (fr.eof) begin
                in_frame <= 1'b0;
                rx_err   <= (cnt != fr.len) || !fr.chk_ok;
            end
        end
    end

    always_ff @(posedge clk) begin
        rx_data <= fr.data;
        if (fr.eof) rx_dlen <= fr.len;   // Header length, held
    end

    a_data_in_frame: assert property (@(posedge clk) disable iff (rst)
        fr.data_en |-> in_frame);

endmodule

// File: hdl/gmii_rx_parser.sv
`timescale 1ns/10ps

module gmii_rx_parser import eth_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  e_rxdv,
    input  byte_t e_rxd,
    frame_if.src  fr
);

    rx_state_t state;
    byte_t     len_hi;
    len_t      len_rx;
    len_t      cnt;
    byte_t     sum;

    assign len_rx = {len_hi, e_rxd};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= RX_IDLE;
            cnt        <= '0;
            fr.sof     <= 1'b0;
            fr.data_en <= 1'b0;
            fr.eof     <= 1'b0;
        end else begin
            fr.sof     <= 1'b0;
            fr.data_en <= 1'b0;
            fr.eof     <= 1'b0;
            if (!e_rxdv) begin
                fr.eof <= (state == RX_DATA) || (state == RX_CHK);   // Truncated frame
                state  <= RX_IDLE;
            end else begin
                case (state)
                    RX_IDLE: state <= (e_rxd == PREAMBLE_BYTE) ? RX_PRE : RX_DROP;
                    RX_PRE: begin
                        if (e_rxd == SFD_BYTE) state <= RX_LEN_HI;
                        else if (e_rxd != PREAMBLE_BYTE) state <= RX_DROP;
                    end
                    RX_LEN_HI: state <= RX_LEN_LO;
                    RX_LEN_LO: begin
                        cnt <= '0;
                        if (len_rx > len_t'(MAX_PAYLOAD)) begin
                            state <= RX_DROP;
                        end else begin
                            fr.sof <= 1'b1;
                            state  <= (len_rx == '0) ? RX_CHK : RX_DATA;
                        end
                    end
                    RX_DATA: begin
                        fr.data_en <= 1'b1;
                        cnt        <= cnt + 1'b1;
                        if (cnt == fr.len - 1'b1) state <= RX_CHK;
                    end
                    RX_CHK: begin
                        fr.eof <= 1'b1;
                        state  <= RX_IDLE;
                    end
                    RX_DROP: state <= RX_DROP;   // Until e_rxdv falls
                    default: state <= RX_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        fr.data <= e_rxd;
        if (state == RX_LEN_HI) len_hi <= e_rxd;
        if (state == RX_LEN_LO) begin
            fr.len <= len_rx;
            sum    <= '0;
        end else if (state == RX_DATA) begin
            sum <= sum + e_rxd;
        end
        if (state == RX_DATA || state == RX_CHK) begin
            fr.chk_ok <= e_rxdv && (state == RX_CHK) && (e_rxd == sum);
        end
    end

endmodule

// File: hdl/udp_frame_tx.sv
`timescale 1ns/10ps

module udp_frame_tx import eth_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             fs_send,
    input  len_t             tx_dlen,
    input  byte_t            fifo_dout,
    input  logic [FIFO_AW:0] fifo_level,
    output logic             fifo_rd_en,
    output logic             e_txen,
    output byte_t            e_txd,
    output logic             fd_send
);

    tx_state_t state;
    len_t      cnt;
    len_t      dlen;
    byte_t     chk;
    logic      last_pre;
    logic      last_data;

    assign last_pre  = (cnt == len_t'(PREAMBLE_LEN - 1));
    assign last_data = (cnt == dlen - 1'b1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= TX_IDLE;
            cnt   <= '0;
        end else begin
            cnt <= '0;
            case (state)
                TX_IDLE: if (fs_send) state <= TX_LOAD;
                TX_LOAD: if (len_t'(fifo_level) >= dlen) state <= TX_PRE;   // Wait for payload
                TX_PRE: begin
                    cnt <= cnt + 1'b1;
                    if (last_pre) state <= TX_SFD;
                end
                TX_SFD:    state <= TX_LEN_HI;
                TX_LEN_HI: state <= TX_LEN_LO;
                TX_LEN_LO: state <= (dlen == '0) ? TX_CHK : TX_DATA;
                TX_DATA: begin
                    cnt <= cnt + 1'b1;
                    if (last_data) state <= TX_CHK;
                end
                TX_CHK:  state <= TX_DONE;
                TX_DONE: state <= TX_IDLE;
                default: state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == TX_IDLE && fs_send) dlen <= tx_dlen;
        if (state == TX_LOAD) chk <= '0;
        else if (state == TX_DATA) chk <= chk + fifo_dout;   // Running sum mod 256
    end

    assign fifo_rd_en = (state == TX_DATA);
    assign fd_send    = (state == TX_DONE);
    assign e_txen     = state inside {TX_PRE, TX_SFD, TX_LEN_HI, TX_LEN_LO, TX_DATA, TX_CHK};

    always_comb begin
        case (state)
            TX_PRE:    e_txd = PREAMBLE_BYTE;
            TX_SFD:    e_txd = SFD_BYTE;
            TX_LEN_HI: e_txd = dlen[15:8];
            TX_LEN_LO: e_txd = dlen[7:0];
            TX_DATA:   e_txd = fifo_dout;
            TX_CHK:    e_txd = chk;
            default:   e_txd = 8'h00;
        endcase
    end

    // LOAD must have left enough bytes for every pop
    a_rd_in_data: assert property (@(posedge clk) disable iff (rst)
        fifo_rd_en |-> (fifo_level != '0));

endmodule

// File: hdl/byte_fifo.sv
`timescale 1ns/10ps

module byte_fifo import eth_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             wr_en,
    input  byte_t            din,
    input  logic             rd_en,
    output byte_t            dout,
    output logic             full,
    output logic [FIFO_AW:0] level
);

    byte_t              mem [MAX_PAYLOAD];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic               do_wr;
    logic               do_rd;

    assign full  = (level == (FIFO_AW + 1)'(MAX_PAYLOAD));
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && (level != '0);
    assign dout  = mem[rd_ptr];   // Show-ahead

    always_ff @(posedge clk) begin
        if (do_wr) mem[wr_ptr] <= din;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    a_level_bound: assert property (@(posedge clk) disable iff (rst)
        level <= (FIFO_AW + 1)'(MAX_PAYLOAD));

endmodule

// File: hdl/frame_if.sv
`timescale 1ns/10ps

interface frame_if import eth_pkg::*; ();

    logic  sof;       // Header done, len valid
    len_t  len;
    logic  data_en;
    byte_t data;
    logic  eof;       // Check byte seen or early end
    logic  chk_ok;

    modport src (
        output sof, len, data_en, data, eof, chk_ok
    );

    modport dst (
        input sof, len, data_en, data, eof, chk_ok
    );

endinterface

// File: hdl/eth_pkg.sv
package eth_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] len_t;

    localparam byte_t PREAMBLE_BYTE = 8'h55;
    localparam byte_t SFD_BYTE      = 8'hD5;
    localparam int    PREAMBLE_LEN  = 7;
    localparam int    MAX_PAYLOAD   = 64;   // Also the FIFO depth
    localparam int    FIFO_AW       = 6;

    typedef enum logic [3:0] {
        TX_IDLE,
        TX_LOAD,
        TX_PRE,
        TX_SFD,
        TX_LEN_HI,
        TX_LEN_LO,
        TX_DATA,
        TX_CHK,
        TX_DONE
    } tx_state_t;

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_PRE,
        RX_LEN_HI,
        RX_LEN_LO,
        RX_DATA,
        RX_CHK,
        RX_DROP
    } rx_state_t;

endpackage
